// File: sim.f
+incdir+design
design/iq_pkg.sv
design/instr_decoder.sv
design/instruction_queue.sv
design/issue_ctrl.sv
design/decode_issue_top.sv
tests/tb_clock_gen.sv
tests/decode_issue_assert.sv
tests/tb_decode_issue.sv

// File: tests/tb_decode_issue.sv
/*
 * Decode and issue testbench
 * Table-driven fetch, stall and flush stimulus against a reference queue
 * of expected records, covering decode, order, back-pressure, multiply hold and flush
 */
`timescale 1ns/1ns
`default_nettype none

`include "iq_params.svh"

module tb_decode_issue;

    localparam int WAIT_LIMIT = 200;   // Cycles allowed for any single wait

    typedef struct packed {
        logic                 valid;   // Present a fetch word
        logic [31:0]          word;
        iq_pkg::id_ir_stage_t exp;     // Record the word must issue as
        logic                 stall;
        logic                 flush;
        logic                 sync;    // Wait for an empty pipeline first
        logic                 chk;     // Compare fetch_ready_o before driving
        logic                 rdy;
    } row_t;

    logic                 clk_i;
    logic                 rstn_i;
    logic                 flush_i;
    logic                 fetch_valid_i;
    logic [31:0]          fetch_word_i;
    logic                 exe_stall_i;
    logic                 fetch_ready_o;
    iq_pkg::id_ir_stage_t issued_o;

    row_t                 rows[$];
    iq_pkg::id_ir_stage_t exp_q[$];    // Reference queue, oldest first
    int                   in_flight;   // Fetched but not yet seen on issued_o
    int                   error_count;
    int                   cyc = 0;
    int                   last_mul_cyc;
    logic                 mul_seen;    // Last issue was a MUL
    logic [15:0]          lfsr;

    tb_clock_gen u_clk (.clk_o(clk_i), .rstn_o(rstn_i));

    decode_issue_top UUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_word_i  (fetch_word_i),
        .exe_stall_i   (exe_stall_i),
        .fetch_ready_o (fetch_ready_o),
        .issued_o      (issued_o)
    );

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic add_row(input logic valid, input logic [31:0] word,
                           input iq_pkg::id_ir_stage_t exp, input logic stall,
                           input logic flush, input logic sync, input logic chk,
                           input logic rdy);
        row_t r;
        r = '{valid, word, exp, stall, flush, sync, chk, rdy};
        rows.push_back(r);
    endtask

    task automatic add_idle(input logic stall, input logic flush, input logic sync,
                            input logic chk, input logic rdy);
        add_row(1'b0, '0, '0, stall, flush, sync, chk, rdy);
    endtask

    // Encode one instruction and the record it should decode to
    task automatic add_instr(input iq_pkg::op_e op, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] imm, input logic stall);
        iq_pkg::id_ir_stage_t e;
        logic [31:0]          w;
        logic [6:0]           f7;
        e             = '0;
        e.instr.valid = 1'b1;
        e.instr.op    = op;
        f7 = (op == iq_pkg::OP_SUB) ? 7'b0100000 :
             (op == iq_pkg::OP_MUL) ? 7'b0000001 : 7'b0000000;
        case (op)
            iq_pkg::OP_ADDI: begin
                w           = {imm[11:0], rs1, 3'b000, rd, `OPC_OP_IMM};
                e.instr.rd  = rd;
                e.instr.rs1 = rs1;
                e.instr.imm = {{20{imm[11]}}, imm[11:0]};   // Sign extended
            end
            iq_pkg::OP_LUI: begin
                w           = {imm[31:12], rd, `OPC_LUI};
                e.instr.rd  = rd;
                e.instr.imm = {imm[31:12], 12'h000};
            end
            iq_pkg::OP_ADD, iq_pkg::OP_SUB, iq_pkg::OP_MUL: begin
                w           = {f7, rs2, rs1, 3'b000, rd, `OPC_OP};
                e.instr.rd  = rd;
                e.instr.rs1 = rs1;
                e.instr.rs2 = rs2;
            end
            default: begin
                w         = {imm[31:7], 7'b1100011};   // Branch opcode, outside the subset
                e.illegal = 1'b1;
            end
        endcase
        add_row(1'b1, w, e, stall, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic check_issued(input iq_pkg::id_ir_stage_t act,
                                input iq_pkg::id_ir_stage_t exp, input string msg);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %s %h, expected %s %h", $time, msg,
                     act.instr.op.name(), act, exp.instr.op.name(), exp);
        end
    endtask

    task automatic check_ready(input logic act, input logic exp, input string msg);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, msg, act, exp);
        end
    endtask

    task automatic finish_run();
        $display("Error count: %0d", error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        error_count++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic drive(input logic valid, input logic [31:0] word, input logic stall,
                         input logic flush);
        fetch_valid_i = valid;
        fetch_word_i  = word;
        exe_stall_i   = stall;
        flush_i       = flush;
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;   // Inputs change 1 ns after the edge
    endtask

    task automatic apply_row(input row_t r);
        int n;
        n = 0;
        while (r.sync && in_flight != 0) begin   // Idle until all issued
            drive(1'b0, '0, 1'b0, 1'b0);
            step();
            n++;
            if (n > WAIT_LIMIT) fail_timeout("the pipeline to drain");
        end
        n = 0;
        while (r.valid && !(fetch_ready_o && in_flight < `IQ_NUM_ENTRIES)) begin
            drive(1'b0, '0, 1'b0, 1'b0);   // Keep words in flight within the depth
            step();
            n++;
            if (n > WAIT_LIMIT) fail_timeout("room for a fetch word");
        end
        if (r.chk) check_ready(fetch_ready_o, r.rdy, "fetch_ready_o level");
        drive(r.valid, r.word, r.stall, r.flush);
        if (r.valid && !r.flush) begin
            exp_q.push_back(r.exp);
            in_flight++;
        end
        @(posedge clk_i);
        if (r.flush) begin   // Nothing fetched before now may issue
            exp_q.delete();
            in_flight = 0;
            mul_seen  = 1'b0;
        end
        #1;
    endtask

    task automatic build_table();
        int          i;
        iq_pkg::op_e op;
        add_idle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);   // Ready right after reset
        repeat (3) add_idle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        // Decode of each op and one illegal word
        add_instr(iq_pkg::OP_ADDI, 5'd1, 5'd2, 5'd0, 32'hFFF, 1'b0);
        add_instr(iq_pkg::OP_ADDI, 5'd3, 5'd4, 5'd0, 32'h7FF, 1'b0);
        add_instr(iq_pkg::OP_ADD, 5'd5, 5'd6, 5'd7, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_SUB, 5'd31, 5'd30, 5'd29, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_LUI, 5'd8, 5'd0, 5'd0, 32'hABCDE000, 1'b0);
        add_instr(iq_pkg::OP_MUL, 5'd9, 5'd10, 5'd11, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'h12345680, 1'b0);
        // Multiply hold, back to back MULs then ALU ops
        add_idle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        add_instr(iq_pkg::OP_MUL, 5'd12, 5'd13, 5'd14, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_MUL, 5'd15, 5'd12, 5'd1, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_ADD, 5'd16, 5'd15, 5'd12, 32'h0, 1'b0);
        add_instr(iq_pkg::OP_ADDI, 5'd17, 5'd16, 5'd0, 32'h801, 1'b0);
        // Back-pressure from an empty queue
        add_idle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        for (i = 0; i < `IQ_NUM_ENTRIES; i++) begin
            add_instr(iq_pkg::OP_ADDI, 5'(i + 1), 5'(i), 5'd0, 32'(i * 3), 1'b1);
        end
        add_idle(1'b1, 1'b0, 1'b0, 1'b1, 1'b1);   // Last word still in decode
        add_idle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);   // Queue full
        add_idle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);   // Stall released
        add_idle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        // Flush of entries held behind a stall
        add_idle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        for (i = 0; i < 4; i++) begin
            add_instr(iq_pkg::OP_SUB, 5'(20 + i), 5'd1, 5'd2, 32'h0, 1'b1);
        end
        add_idle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        add_instr(iq_pkg::OP_LUI, 5'd24, 5'd0, 5'd0, 32'h00001000, 1'b0);
        add_instr(iq_pkg::OP_ADD, 5'd25, 5'd24, 5'd3, 32'h0, 1'b0);
        // Flush while the queue drains
        add_idle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        for (i = 0; i < 5; i++) begin
            add_instr(iq_pkg::OP_ADD, 5'(i + 1), 5'd7, 5'(i), 32'h0, 1'b0);
        end
        add_idle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_instr(iq_pkg::OP_ADDI, 5'd26, 5'd0, 5'd0, 32'h123, 1'b0);
        // Random ops with random stalls
        add_idle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        for (i = 0; i < 24; i++) begin
            op = iq_pkg::op_e'(rand_bits(3) % 6);
            add_instr(op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)), rand_bits(32),
                      2'(rand_bits(2)) == 2'b00);
        end
    endtask

    always @(posedge clk_i) cyc <= cyc + 1;

    // Issue monitor, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rstn_i && issued_o.instr.valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Unexpected instruction issued at %0t ns: %h", $time, issued_o);
            end else begin
                check_issued(issued_o, exp_q.pop_front(), "issued record");
                in_flight--;
            end
            if (mul_seen && (cyc - last_mul_cyc) < `MUL_LATENCY) begin
                error_count++;
                $display("CHECK FAILED at %0t ns: issue %0d cycles after a MUL, minimum %0d",
                         $time, cyc - last_mul_cyc, `MUL_LATENCY);
            end
            mul_seen     = (issued_o.instr.op == iq_pkg::OP_MUL);
            last_mul_cyc = cyc;
        end
    end

    initial begin
        int n;
        lfsr         = 16'd59395;
        error_count  = 0;
        in_flight    = 0;
        mul_seen     = 1'b0;
        last_mul_cyc = 0;
        drive(1'b0, '0, 1'b0, 1'b0);
        build_table();
        @(posedge clk_i);
        @(negedge clk_i);   // Still in reset
        check_ready(fetch_ready_o, 1'b0, "fetch_ready_o during reset");
        check_issued(issued_o, '0, "issued_o during reset");
        n = 0;
        while (rstn_i !== 1'b1) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT) fail_timeout("reset release");
        end
        step();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        n = 0;
        while (exp_q.size() != 0) begin   // Drain the tail of the table
            drive(1'b0, '0, 1'b0, 1'b0);
            step();
            n++;
            if (n > WAIT_LIMIT) fail_timeout("the last issues");
        end
        repeat (4) step();   // Catch late extra issues
        finish_run();
    end

endmodule

`default_nettype wire

// File: tests/decode_issue_assert.sv
/*
 * Instruction queue assertions
 * Occupancy flags, head pops and flush behavior
 */
`timescale 1ns/1ns
`default_nettype none

module decode_issue_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic flush_i,
    input logic read_head_i,
    input logic full_i,
    input logic empty_i
);

    // Full is forced in reset, so only checked outside it
    assert property (@(posedge clk_i) disable iff (!rstn_i) !(full_i && empty_i))
        else $error("Queue reports full and empty together");

    assert property (@(posedge clk_i) disable iff (!rstn_i) read_head_i |-> !empty_i)
        else $error("Head read requested from an empty queue");

    // Flush empties the queue at the same edge
    assert property (@(posedge clk_i) disable iff (!rstn_i) flush_i |=> empty_i)
        else $error("Queue not empty in the cycle after a flush");

endmodule

bind instruction_queue decode_issue_assert u_queue_assert (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .flush_i     (flush_i),
    .read_head_i (read_head_i),
    .full_i      (full_o),
    .empty_i     (empty_o)
);

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 4 ns clock, active-low reset held for three rising edges
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD = 2;   // 4 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 rstn_o = 1'b1;   // Release away from the clock edge
    end

endmodule

`default_nettype wire

// File: design/decode_issue_top.sv
/*
 * Decode and issue front end
 * Fetch words go through the decoder into the instruction queue,
 * the issue controller drains it towards execute
 */
`timescale 1ns/1ns
`default_nettype none

module decode_issue_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    input  logic                 fetch_valid_i,
    input  logic [31:0]          fetch_word_i,
    input  logic                 exe_stall_i,
    output logic                 fetch_ready_o,  // Low while the queue is full
    output iq_pkg::id_ir_stage_t issued_o
);

    iq_pkg::id_ir_stage_t decoded;    // Decoder register to queue
    iq_pkg::id_ir_stage_t iq_head;    // Queue head to issue
    logic                 iq_full;
    logic                 iq_empty;
    logic                 read_head;

    instr_decoder u_decoder (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_word_i  (fetch_word_i),
        .decoded_o     (decoded)
    );

    instruction_queue u_queue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (decoded),
        .flush_i       (flush_i),
        .read_head_i   (read_head),
        .instruction_o (iq_head),
        .full_o        (iq_full),
        .empty_o       (iq_empty)
    );

    issue_ctrl u_issue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .exe_stall_i (exe_stall_i),
        .head_i      (iq_head),
        .empty_i     (iq_empty),
        .read_head_o (read_head),
        .issued_o    (issued_o)
    );

    assign fetch_ready_o = ~iq_full;   // Also low in reset

endmodule

`default_nettype wire

// File: design/issue_ctrl.sv
/*
 * Issue controller
 * Pops the queue head into a registered issue slot and holds
 * further issue while a multi-cycle multiply occupies execute
 */
`timescale 1ns/1ns
`default_nettype none

`include "iq_params.svh"

module issue_ctrl (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,      // Abort hold and suppress issue
    input  logic                 exe_stall_i,  // Execute side cannot accept
    input  iq_pkg::id_ir_stage_t head_i,       // Current queue head
    input  logic                 empty_i,
    output logic                 read_head_o,  // One-cycle pop request
    output iq_pkg::id_ir_stage_t issued_o      // Valid pulses once per issue
);

    localparam int unsigned CNT_W = $clog2(`MUL_LATENCY);
    // Busy cycles after the multiply issues, counted down to zero
    localparam logic [CNT_W-1:0] MUL_HOLD = CNT_W'(`MUL_LATENCY - 2);

    iq_pkg::issue_state_e state;
    logic [CNT_W-1:0]     mul_cnt;   // Remaining busy cycles minus one

    logic issue_go;
    logic head_is_mul;

    // Issue only from idle with something queued and execute free
    assign issue_go    = (state == iq_pkg::ISSUE_IDLE) & ~empty_i & ~exe_stall_i & ~flush_i;
    assign head_is_mul = (head_i.instr.op == iq_pkg::OP_MUL);
    assign read_head_o = issue_go;

    // Multiply hold state machine
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= iq_pkg::ISSUE_IDLE;
            mul_cnt <= '0;
        end else if (flush_i) begin
            state   <= iq_pkg::ISSUE_IDLE;
            mul_cnt <= '0;
        end else begin
            case (state)
                iq_pkg::ISSUE_IDLE: begin
                    if (issue_go && head_is_mul) begin
                        state   <= iq_pkg::ISSUE_MUL_BUSY;   // Execute taken by the multiply
                        mul_cnt <= MUL_HOLD;
                    end
                end
                iq_pkg::ISSUE_MUL_BUSY: begin
                    if (mul_cnt == '0) begin
                        state <= iq_pkg::ISSUE_IDLE;        // Issue allowed again next cycle
                    end else begin
                        mul_cnt <= mul_cnt - CNT_W'(1);
                    end
                end
                default: begin
                    state   <= iq_pkg::ISSUE_IDLE;
                    mul_cnt <= '0;
                end
            endcase
        end
    end

    // Issue slot, valid only in the cycle after a pop
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            issued_o <= '0;
        end else if (issue_go) begin
            issued_o <= head_i;
        end else begin
            issued_o <= '0;   // Bubble
        end
    end

endmodule

`default_nettype wire

// File: design/instruction_queue.sv
/*
 * Instruction queue
 * Circular buffer of decoded records between decode and issue,
 * with head and tail pointers, an occupancy count and a flush
 */
`timescale 1ns/1ns
`default_nettype none

`include "iq_params.svh"

module instruction_queue (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  iq_pkg::id_ir_stage_t instruction_i,  // Written when its valid bit is set
    input  logic                 flush_i,        // Empty the queue
    input  logic                 read_head_i,    // Pop the head entry
    output iq_pkg::id_ir_stage_t instruction_o,  // Head entry, zero when empty
    output logic                 full_o,
    output logic                 empty_o
);

    localparam int unsigned PTR_W = $clog2(`IQ_NUM_ENTRIES);
    localparam logic [PTR_W:0]   DEPTH    = (PTR_W + 1)'(`IQ_NUM_ENTRIES);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`IQ_NUM_ENTRIES - 1);

    logic [PTR_W-1:0] head;   // Oldest entry
    logic [PTR_W-1:0] tail;   // Next free slot
    logic [PTR_W:0]   count;  // One bit wider so a full queue fits

    logic write_en;
    logic read_en;

    iq_pkg::id_ir_stage_t buffer [0:`IQ_NUM_ENTRIES-1];

    // Pointer advance with wrap at the last slot
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign write_en = instruction_i.instr.valid & (count < DEPTH);  // Overflow drops the word
    assign read_en  = read_head_i & (count != '0);

    // Storage, payload only
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            buffer[tail] <= instruction_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;   // Pending entries are discarded
            tail  <= '0;
            count <= '0;
        end else begin
            if (read_en) begin
                head <= next_ptr(head);
            end
            if (write_en) begin
                tail <= next_ptr(tail);
            end
            // Simultaneous read and write leaves the count unchanged
            count <= count + (PTR_W + 1)'(write_en) - (PTR_W + 1)'(read_en);
        end
    end

    assign empty_o       = (count == '0);
    assign full_o        = (count == DEPTH) | ~rstn_i;      // Blocks fetch during reset
    assign instruction_o = empty_o ? '0 : buffer[head];

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
/*
 * Instruction decoder
 * Registered decode of a raw RV32 fetch word into an issue record
 * Supports ADDI, ADD, SUB, LUI and MUL, anything else flagged illegal
 */
`timescale 1ns/1ns
`default_nettype none

`include "iq_params.svh"

module instr_decoder (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,        // Drop the registered record
    input  logic                 fetch_valid_i,  // Strobe for fetch_word_i
    input  logic [31:0]          fetch_word_i,
    output iq_pkg::id_ir_stage_t decoded_o
);

    // Instruction word fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd_f;
    logic [4:0]  rs1_f;
    logic [4:0]  rs2_f;
    logic [31:0] imm_i;   // I-type, sign extended
    logic [31:0] imm_u;   // U-type, low 12 bits zero

    iq_pkg::id_ir_stage_t dec_next;

    assign opcode = fetch_word_i[6:0];
    assign rd_f   = fetch_word_i[11:7];
    assign funct3 = fetch_word_i[14:12];
    assign rs1_f  = fetch_word_i[19:15];
    assign rs2_f  = fetch_word_i[24:20];
    assign funct7 = fetch_word_i[31:25];

    assign imm_i = {{20{fetch_word_i[31]}}, fetch_word_i[31:20]};
    assign imm_u = {fetch_word_i[31:12], 12'h000};

    // Start from an illegal record, legal branches fill in the fields
    always_comb begin
        dec_next             = '0;
        dec_next.instr.valid = 1'b1;
        dec_next.instr.op    = iq_pkg::OP_ILLEGAL;
        dec_next.illegal     = 1'b1;

        case (opcode)
            `OPC_OP_IMM: begin
                if (funct3 == `F3_ADD_SUB) begin   // Only ADDI from the immediate group
                    dec_next.instr.op  = iq_pkg::OP_ADDI;
                    dec_next.instr.rd  = rd_f;
                    dec_next.instr.rs1 = rs1_f;
                    dec_next.instr.imm = imm_i;
                    dec_next.illegal   = 1'b0;
                end
            end
            `OPC_OP: begin
                if (funct3 == `F3_ADD_SUB &&
                    (funct7 == `F7_BASE || funct7 == `F7_SUB || funct7 == `F7_MULDIV)) begin
                    dec_next.instr.rd  = rd_f;
                    dec_next.instr.rs1 = rs1_f;
                    dec_next.instr.rs2 = rs2_f;
                    dec_next.illegal   = 1'b0;
                    case (funct7)
                        `F7_SUB:    dec_next.instr.op = iq_pkg::OP_SUB;
                        `F7_MULDIV: dec_next.instr.op = iq_pkg::OP_MUL;
                        default:    dec_next.instr.op = iq_pkg::OP_ADD;
                    endcase
                end
            end
            `OPC_LUI: begin
                dec_next.instr.op  = iq_pkg::OP_LUI;
                dec_next.instr.rd  = rd_f;
                dec_next.instr.imm = imm_u;
                dec_next.illegal   = 1'b0;
            end
            default: begin
                // Stays illegal with zero fields
            end
        endcase
    end

    // Output register, one cycle of decode latency
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            decoded_o <= '0;
        end else if (flush_i || !fetch_valid_i) begin
            decoded_o <= '0;          // No instruction this cycle
        end else begin
            decoded_o <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: design/iq_pkg.sv
/*
 * Decode and issue types
 * Operation and state encodings plus the records passed from
 * the decoder through the instruction queue to issue
 */
`default_nettype none

package iq_pkg;

    // Operations understood by the decoder
    typedef enum logic [2:0] {
        OP_ADDI    = 3'd0,
        OP_ADD     = 3'd1,
        OP_SUB     = 3'd2,
        OP_LUI     = 3'd3,
        OP_MUL     = 3'd4,
        OP_ILLEGAL = 3'd5   // Anything outside the subset
    } op_e;

    // Issue controller states
    typedef enum logic {
        ISSUE_IDLE     = 1'b0,  // Free to pop the queue head
        ISSUE_MUL_BUSY = 1'b1   // Multiply still occupying execute
    } issue_state_e;

    // Decoded instruction fields
    typedef struct packed {
        logic        valid;     // Record carries an instruction
        op_e         op;
        logic [4:0]  rd;        // Destination register
        logic [4:0]  rs1;       // First source, zero when unused
        logic [4:0]  rs2;       // Second source, zero when unused
        logic [31:0] imm;       // Already extended
    } instr_t;

    // Record from decode towards issue
    typedef struct packed {
        instr_t instr;
        logic   illegal;        // Word outside the supported subset
    } id_ir_stage_t;

endpackage

`default_nettype wire

// File: design/iq_params.svh
/*
 * Decode and issue parameters
 * Queue depth, multiply occupancy and RV32 encoding fields
 */
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// Queue sizing
`define IQ_NUM_ENTRIES 8            // Decoded records held between decode and issue

// Execute timing
`define MUL_LATENCY    3            // Cycles a multiply keeps the execute unit busy

// RV32I major opcodes
`define OPC_OP_IMM     7'b0010011   // ADDI and friends
`define OPC_OP         7'b0110011   // Register-register ALU, also RV32M
`define OPC_LUI        7'b0110111

// Function fields used by the supported subset
`define F3_ADD_SUB     3'b000       // Shared by ADDI, ADD, SUB and MUL
`define F7_BASE        7'b0000000   // ADD
`define F7_SUB         7'b0100000
`define F7_MULDIV      7'b0000001   // RV32M group
`endif
